/* hdl/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

////////////////////
// link defaults
////////////////////

`define SPI_DATA_WIDTH      8   // bits per transaction
`define SPI_SCLK_HALFPERIOD 8   // clk cycles per sclk half period

`endif

/* hdl/spi_master_ctrl.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"
`default_nettype none

// mode 1 framing: cs, sclk, bit count and datapath strobes
module spi_master_ctrl #(
  parameter int data_width = `SPI_DATA_WIDTH
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start_transaction,
  input  logic               tick,     // half-period tick from the timer
  output logic               restart,  // realign the timer on an accepted start
  output spi_pkg::spi_ctrl_t ctrl,
  output logic               sclk,
  output logic               cs,
  output logic               ready
);

  localparam int bc_w = (data_width > 1) ? $clog2(data_width) : 1;
  localparam logic [bc_w-1:0] last_bit = bc_w'(data_width - 1);

  spi_pkg::spi_state_e state;
  spi_pkg::spi_state_e state_next;

  logic [bc_w-1:0] bit_cnt;  // bits still to go after the current one
  logic            accept;

  assign ready  = (state == spi_pkg::st_idle);
  assign accept = ready && start_transaction;  // busy starts fall through

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_next = state;
    case (state)
      spi_pkg::st_idle: begin
        if (accept) begin
          state_next = spi_pkg::st_wait_sclk_1;
        end
      end
      spi_pkg::st_wait_sclk_1: begin
        if (tick) begin
          state_next = spi_pkg::st_wait_sclk_0;
        end
      end
      spi_pkg::st_wait_sclk_0: begin
        if (tick) begin
          // last falling edge leads into the trailing half period
          if (bit_cnt == '0) begin
            state_next = spi_pkg::st_finalize;
          end else begin
            state_next = spi_pkg::st_wait_sclk_1;
          end
        end
      end
      spi_pkg::st_finalize: begin
        if (tick) begin
          state_next = spi_pkg::st_idle;
        end
      end
      default: begin
        state_next = spi_pkg::st_idle;
      end
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= spi_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (accept) begin
      bit_cnt <= last_bit;
    end else if ((state == spi_pkg::st_wait_sclk_0) && tick && (bit_cnt != '0)) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // sclk idles low, cpol 0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk <= 1'b0;
    end else if (tick && (state == spi_pkg::st_wait_sclk_1)) begin
      sclk <= 1'b1;
    end else if (tick && (state == spi_pkg::st_wait_sclk_0)) begin
      sclk <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cs <= 1'b1;
    end else if (accept) begin
      cs <= 1'b0;  // select on the edge after the start
    end else if (tick && (state == spi_pkg::st_finalize)) begin
      cs <= 1'b1;
    end
  end

  ////////////////////
  // strobes
  ////////////////////

  assign restart = accept;

  always_comb begin
    ctrl        = '0;
    ctrl.load   = accept;
    ctrl.launch = tick && (state == spi_pkg::st_wait_sclk_1);  // with sclk rise
    ctrl.sample = tick && (state == spi_pkg::st_wait_sclk_0);  // with sclk fall
  end

  ////////////////////
  // checks
  ////////////////////

  cs_low_when_busy : assert property (
    @(posedge clk) disable iff (rst)
    (state != spi_pkg::st_idle) |-> !cs
  ) else $error("spi_master_ctrl: cs high during a transaction");

  sclk_low_when_deselected : assert property (
    @(posedge clk) disable iff (rst)
    cs |-> !sclk
  ) else $error("spi_master_ctrl: sclk high while cs is high");

  // outside a tick nothing may move, so a busy start must leave all alone
  busy_start_ignored : assert property (
    @(posedge clk) disable iff (rst)
    (start_transaction && !ready && !tick) |=>
      $stable(state) && $stable(bit_cnt) && $stable(cs) && $stable(sclk)
  ) else $error("spi_master_ctrl: start while busy changed the frame");

endmodule

`default_nettype wire

/* hdl/spi_master_top.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"
`default_nettype none

// single-lane mode 1 spi master
module spi_master_top #(
  parameter int data_width      = `SPI_DATA_WIDTH,
  parameter int sclk_halfperiod = `SPI_SCLK_HALFPERIOD
) (
  input  logic                  clk,
  input  logic                  rst,
  // host side
  input  logic                  start_transaction,  // one cycle, only while ready
  input  logic [data_width-1:0] data_in,
  output logic [data_width-1:0] data_out,
  output logic                  ready,
  // spi pins
  output logic                  mosi,
  input  logic                  miso,
  output logic                  sclk,
  output logic                  cs
);

  logic               tick;
  logic               restart;
  spi_pkg::spi_ctrl_t ctrl;

  ////////////////////
  // control
  ////////////////////

  spi_master_ctrl #(
    .data_width (data_width)
  ) ctrl_inst (
    .clk               (clk),
    .rst               (rst),
    .start_transaction (start_transaction),
    .tick              (tick),
    .restart           (restart),
    .ctrl              (ctrl),
    .sclk              (sclk),
    .cs                (cs),
    .ready             (ready)
  );

  spi_sclk_timer #(
    .sclk_halfperiod (sclk_halfperiod)
  ) timer_inst (
    .clk     (clk),
    .rst     (rst),
    .restart (restart),
    .tick    (tick)
  );

  ////////////////////
  // datapath
  ////////////////////

  spi_shift_reg #(
    .data_width (data_width)
  ) shift_inst (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .miso     (miso),
    .mosi     (mosi),
    .data_out (data_out)
  );

endmodule

`default_nettype wire

/* hdl/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  ////////////////////
  // controller states
  ////////////////////

  typedef enum logic [1:0] {
    st_idle        = 2'd0,  // cs high, waiting for a start
    st_wait_sclk_1 = 2'd1,  // sclk low, next tick raises it
    st_wait_sclk_0 = 2'd2,  // sclk high, next tick lowers it
    st_finalize    = 2'd3   // last bit done, hold cs for one half period
  } spi_state_e;

  ////////////////////
  // datapath strobes
  ////////////////////

  // one-cycle strobes from the controller to the shift register
  typedef struct packed {
    logic load;    // take data_in into the transmit shifter
    logic launch;  // next bit to mosi, rising sclk edge
    logic sample;  // shift miso in, falling sclk edge
  } spi_ctrl_t;

endpackage

`default_nettype wire

/* hdl/spi_sclk_timer.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"
`default_nettype none

// half-period tick generator for the sclk
module spi_sclk_timer #(
  parameter int sclk_halfperiod = `SPI_SCLK_HALFPERIOD
) (
  input  logic clk,
  input  logic rst,
  input  logic restart,  // reload now, first tick comes a full half period later
  output logic tick
);

  // keep at least one bit when a half period is a single cycle
  localparam int cnt_w = (sclk_halfperiod > 1) ? $clog2(sclk_halfperiod) : 1;
  localparam logic [cnt_w-1:0] reload_val = cnt_w'(sclk_halfperiod - 1);

  logic [cnt_w-1:0] count;

  ////////////////////
  // down counter
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= reload_val;
    end else if (restart || (count == '0)) begin
      count <= reload_val;
    end else begin
      count <= count - 1'b1;
    end
  end

  assign tick = (count == '0);  // high for the zero cycle only

  ////////////////////
  // checks
  ////////////////////

  generate
    if (sclk_halfperiod > 1) begin : g_tick_check
      // a tick is always followed by at least one quiet cycle
      tick_single_cycle : assert property (
        @(posedge clk) disable iff (rst)
        tick |=> !tick
      ) else $error("spi_sclk_timer: tick held for two cycles");
    end
  endgenerate

endmodule

`default_nettype wire

/* hdl/spi_shift_reg.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"
`default_nettype none

// transmit and receive shifters for one spi lane, msb first
// data_width must be 2 or more
module spi_shift_reg #(
  parameter int data_width = `SPI_DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst,
  input  spi_pkg::spi_ctrl_t    ctrl,
  input  logic [data_width-1:0] data_in,
  input  logic                  miso,
  output logic                  mosi,
  output logic [data_width-1:0] data_out  // last completed word
);

  localparam int cnt_w = $clog2(data_width);
  localparam logic [cnt_w-1:0] last_sample = cnt_w'(data_width - 1);

  logic [data_width-1:0] tx_shift;
  logic [data_width-1:0] rx_shift;
  logic [data_width-1:0] rx_next;
  logic [cnt_w-1:0]      sample_cnt;

  // receive word including the bit arriving this cycle
  assign rx_next = {rx_shift[data_width-2:0], miso};

  ////////////////////
  // payload shifters
  ////////////////////

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      tx_shift <= data_in;
    end else if (ctrl.launch) begin
      tx_shift <= {tx_shift[data_width-2:0], 1'b0};
    end
    if (ctrl.sample) begin
      rx_shift <= rx_next;
    end
  end

  ////////////////////
  // mosi and capture
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mosi <= 1'b0;
    end else if (ctrl.launch) begin
      mosi <= tx_shift[data_width-1];  // msb goes first
    end
  end

  // counts samples so the word is captured on the last one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sample_cnt <= '0;
      data_out   <= '0;
    end else if (ctrl.load) begin
      sample_cnt <= '0;
    end else if (ctrl.sample) begin
      if (sample_cnt == last_sample) begin
        sample_cnt <= '0;
        data_out   <= rx_next;
      end else begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // rising and falling sclk edges can't share a cycle
  launch_sample_excl : assert property (
    @(posedge clk) disable iff (rst)
    !(ctrl.launch && ctrl.sample)
  ) else $error("spi_shift_reg: launch and sample together");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the spi master testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module spi_master_tb -f spi_master.f -o spi_master_sim > "$log" 2>&1 &&
  ./obj_dir/spi_master_sim >> "$log" 2>&1

# the testbench prints its verdict into the log
grep -q "SIMULATION PASSED" "$log" &&
  { echo "run passed, see $log"; exit 0; } ||
  { echo "run failed, see $log"; exit 1; }

/* spi_master.f */
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_sclk_timer.sv
hdl/spi_shift_reg.sv
hdl/spi_master_ctrl.sv
hdl/spi_master_top.sv
tests/spi_slave_model.sv
tests/spi_master_tb.sv

/* tests/spi_master_tb.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"
`default_nettype none

module spi_master_tb;

  localparam int width        = `SPI_DATA_WIDTH;
  localparam int half         = `SPI_SCLK_HALFPERIOD;
  localparam int frame_cycles = (2 * width + 1) * half;  // cs low time in clk cycles
  localparam int n_frames     = 26;
  localparam int watchdog_ns  = n_frames * frame_cycles * 20 + 20000;

  logic             clk = 1'b0;
  logic             rst;
  logic             start_transaction;
  logic [width-1:0] data_in;
  logic [width-1:0] data_out;
  logic             ready;
  logic             mosi;
  logic             miso;
  logic             sclk;
  logic             cs;
  logic [width-1:0] reply;     // byte the peripheral returns next
  logic [width-1:0] received;  // byte the peripheral saw last

  logic [width-1:0] frame_tx = '0;  // expected bytes of the running frame
  logic [width-1:0] frame_rx = '0;
  logic             sclk_q   = 1'b0;
  int               low_cnt  = 0;
  int               rise_cnt = 0;
  int               err_cnt  = 0;
  int               pass_cnt = 0;
  int               fail_cnt = 0;
  logic [31:0]      lcg_state;

  always #10 clk = ~clk;

  spi_master_top #(
    .data_width      (width),
    .sclk_halfperiod (half)
  ) spi_master_top_inst (
    .clk               (clk),
    .rst               (rst),
    .start_transaction (start_transaction),
    .data_in           (data_in),
    .data_out          (data_out),
    .ready             (ready),
    .mosi              (mosi),
    .miso              (miso),
    .sclk              (sclk),
    .cs                (cs)
  );

  spi_slave_model #(
    .data_width (width)
  ) slave_inst (
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso),
    .reply    (reply),
    .received (received)
  );

  ////////////////////
  // frame monitor
  ////////////////////

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_q   <= 1'b0;
      low_cnt  <= 0;
      rise_cnt <= 0;
    end else begin
      sclk_q <= sclk;
      if (cs) begin
        low_cnt  <= 0;
        rise_cnt <= 0;
      end else begin
        low_cnt <= low_cnt + 1;
        if (sclk && !sclk_q) rise_cnt <= rise_cnt + 1;
      end
      // a start only counts while ready is high
      if (start_transaction && ready) begin
        frame_tx <= data_in;
        frame_rx <= reply;
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  reset_values : assert property (
    @(posedge clk) (rst || $past(rst)) |-> (cs && !sclk && ready && !mosi && data_out == '0)
  ) else begin
    err_cnt = err_cnt + 1;
    $display("error reset: cs 0x%h sclk 0x%h ready 0x%h mosi 0x%h data_out 0x%h",
             $sampled(cs), $sampled(sclk), $sampled(ready), $sampled(mosi),
             $sampled(data_out));
  end

  frame_rises : assert property (@(posedge clk) disable iff (rst)
    $rose(cs) |-> rise_cnt == width
  ) else begin
    err_cnt = err_cnt + 1;
    $display("error sclk rises: 0x%h expected 0x%h", $sampled(rise_cnt), width);
  end

  frame_length : assert property (@(posedge clk) disable iff (rst)
    $rose(cs) |-> low_cnt == frame_cycles
  ) else begin
    err_cnt = err_cnt + 1;
    $display("error cs low cycles: 0x%h expected 0x%h", $sampled(low_cnt), frame_cycles);
  end

  sclk_idle_low : assert property (@(posedge clk) disable iff (rst) cs |-> !sclk)
  else begin
    err_cnt = err_cnt + 1;
    $display("error sclk: 0x%h expected 0x0 while cs is high", $sampled(sclk));
  end

  ready_tracks_cs : assert property (@(posedge clk) disable iff (rst) ready == cs)
  else begin
    err_cnt = err_cnt + 1;
    $display("error ready: 0x%h expected 0x%h", $sampled(ready), $sampled(cs));
  end

  // peripheral side of mosi, msb first on the mode 1 edges
  tx_byte : assert property (@(posedge clk) disable iff (rst)
    $rose(cs) |-> received == frame_tx
  ) else begin
    err_cnt = err_cnt + 1;
    $display("error received: 0x%h expected 0x%h", $sampled(received), $sampled(frame_tx));
  end

  rx_byte : assert property (@(posedge clk) disable iff (rst)
    $rose(ready) |-> data_out == frame_rx
  ) else begin
    err_cnt = err_cnt + 1;
    $display("error data_out: 0x%h expected 0x%h", $sampled(data_out), $sampled(frame_rx));
  end

  // data_out may only move after the last bit of a frame
  rx_hold : assert property (@(posedge clk) disable iff (rst)
    !$stable(data_out) |-> (!cs && rise_cnt == width)
  ) else begin
    err_cnt = err_cnt + 1;
    $display("error data_out: changed to 0x%h outside the end of a frame",
             $sampled(data_out));
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // called on a falling edge, returns on the first falling edge with ready high
  task automatic run_transaction(input logic [width-1:0] tx, input logic [width-1:0] rx,
                                 input int busy_pulses);
    while (!ready) @(negedge clk);
    start_transaction = 1'b1;
    data_in           = tx;
    reply             = rx;
    @(negedge clk);
    start_transaction = 1'b0;
    for (int k = 0; k < busy_pulses; k++) begin
      repeat (29) @(negedge clk);
      start_transaction = 1'b1;  // should be dropped, master is busy
      data_in           = ~tx;
      @(negedge clk);
      start_transaction = 1'b0;
    end
    while (!ready) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    repeat (2) @(negedge clk);  // let the checks at cs rise run
    if (err_cnt == errs_at_start) begin
      pass_cnt = pass_cnt + 1;
      $display("test %s: ok", name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("test %s: %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int               mark;
    logic [width-1:0] tx;
    logic [width-1:0] rx;
    rst               = 1'b1;
    start_transaction = 1'b0;
    data_in           = '0;
    reply             = '0;
    lcg_state         = 32'h335ded31;

    mark = err_cnt;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    report_test("reset", mark);

    mark = err_cnt;
    run_transaction(8'ha5, 8'h5a, 0);
    report_test("framing", mark);

    mark = err_cnt;
    run_transaction(8'h80, 8'h00, 0);  // single bit at each end shows the order
    run_transaction(8'h01, 8'hff, 0);
    report_test("transmit", mark);

    mark = err_cnt;
    run_transaction(8'h3c, 8'hc3, 0);
    run_transaction(8'h00, 8'h81, 0);
    for (int k = 0; k < 30; k++) begin
      lcg_state = lcg_next(lcg_state);
      data_in   = lcg_state[31 -: width];  // idle noise, data_out must hold
      @(negedge clk);
    end
    report_test("receive", mark);

    mark = err_cnt;
    run_transaction(8'h96, 8'h69, 3);
    report_test("busy start", mark);

    mark = err_cnt;
    for (int i = 0; i < 20; i++) begin
      lcg_state = lcg_next(lcg_state);
      tx        = lcg_state[31 -: width];
      lcg_state = lcg_next(lcg_state);
      rx        = lcg_state[31 -: width];
      run_transaction(tx, rx, 0);
    end
    report_test("random", mark);

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // upper bound from the number of frames, plus room for idle gaps
  initial begin
    #(watchdog_ns);
    $display("watchdog: the tests did not finish in the expected time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/spi_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

// mode 1 peripheral: drives miso on sclk rise, samples mosi on sclk fall
module spi_slave_model #(
  parameter int data_width = 8
) (
  input  logic                  sclk,
  input  logic                  cs,
  input  logic                  mosi,
  output logic                  miso,
  input  logic [data_width-1:0] reply,     // byte returned in the next frame
  output logic [data_width-1:0] received   // last full byte seen on mosi
);

  logic [data_width-1:0] tx_shift = '0;
  logic [data_width-1:0] rx_shift = '0;
  logic [data_width-1:0] rx_word  = '0;
  logic                  miso_q   = 1'b0;

  assign miso     = miso_q;
  assign received = rx_word;

  ////////////////////
  // transmit side
  ////////////////////

  // sclk is low at the cs fall, so the level tells the two events apart
  always @(negedge cs or posedge sclk) begin
    if (sclk) begin
      miso_q   <= tx_shift[data_width-1];  // msb first
      tx_shift <= {tx_shift[data_width-2:0], 1'b0};
    end else begin
      tx_shift <= reply;  // next script byte
    end
  end

  ////////////////////
  // receive side
  ////////////////////

  always @(negedge sclk) begin
    if (!cs) begin
      rx_shift <= {rx_shift[data_width-2:0], mosi};
    end
  end

  // the frame is over once cs goes back up
  always @(posedge cs) begin
    rx_word <= rx_shift;
  end

endmodule

`default_nettype wire
